// File: source/perf_pkg.sv
package perf_pkg;

	// class of a registered access, ACC_NONE when no request was present
	typedef enum logic [1:0] {
		ACC_NONE   = 2'd0,
		ACC_IREAD  = 2'd1,
		ACC_DREAD  = 2'd2,
		ACC_DWRITE = 2'd3
	} acc_kind_t;

	typedef union packed {
		logic [31:0]     word;
		logic [3:0][7:0] bytes;
	} data_word_u;

	typedef struct packed {
		logic        read_request;
		logic        write_request;
		logic [31:0] rw_address;
		logic [31:0] write_data;
		logic [3:0]  write_strobe;
	} core_req_t;

	typedef struct packed {
		logic l1i_miss;
		logic l1d_miss;
		logic l2_miss;
	} miss_flags_t;

	typedef struct packed {
		acc_kind_t   kind;
		logic [29:0] word_index;
		data_word_u  data;
		logic [3:0]  strobe;
		logic        strobe_ok;
		miss_flags_t miss;
	} access_t;

	// the order here is the order of the report frame
	typedef enum logic [2:0] {
		CNT_IREADS      = 3'd0,
		CNT_DREADS      = 3'd1,
		CNT_DWRITES     = 3'd2,
		CNT_BAD_STROBES = 3'd3,
		CNT_L1I_MISSES  = 3'd4,
		CNT_L1D_MISSES  = 3'd5,
		CNT_L2_MISSES   = 3'd6
	} counter_id_t;

	localparam int NUM_COUNTERS = 7;

	localparam logic [7:0] REPORT_SYNC = 8'hA5;

	localparam logic [3:0] STRB_BYTE0   = 4'b0001;
	localparam logic [3:0] STRB_BYTE1   = 4'b0010;
	localparam logic [3:0] STRB_BYTE2   = 4'b0100;
	localparam logic [3:0] STRB_BYTE3   = 4'b1000;
	localparam logic [3:0] STRB_HALF_LO = 4'b0011;
	localparam logic [3:0] STRB_HALF_HI = 4'b1100;
	localparam logic [3:0] STRB_WORD    = 4'b1111;

endpackage

// File: source/access_decode.sv
`timescale 1ns/1ps

module access_decode #(
	parameter logic [31:0] END_INST = 32'h11fd8
) (
	input  logic                  clk,
	input  logic                  arst_n,
	input  perf_pkg::core_req_t   req,
	input  perf_pkg::miss_flags_t miss,
	output perf_pkg::access_t     acc
);

	import perf_pkg::*;

	access_t acc_next;
	logic    strobe_legal;

	// only naturally aligned bytes, halfwords and full words are accepted
	always_comb begin
		case (req.write_strobe)
			STRB_BYTE0,
			STRB_BYTE1,
			STRB_BYTE2,
			STRB_BYTE3,
			STRB_HALF_LO,
			STRB_HALF_HI,
			STRB_WORD: strobe_legal = 1'b1;
			default:   strobe_legal = 1'b0;
		endcase
	end

	always_comb begin
		acc_next = '0;
		// writes into the instruction region still count as data writes
		if (req.write_request) begin
			acc_next.kind = ACC_DWRITE;
		end else if (req.read_request) begin
			if (req.rw_address <= END_INST) begin
				acc_next.kind = ACC_IREAD;
			end else begin
				acc_next.kind = ACC_DREAD;
			end
		end
		acc_next.word_index = req.rw_address[31:2];
		acc_next.data.word  = req.write_data;
		acc_next.strobe     = req.write_strobe;
		acc_next.strobe_ok  = req.write_request & strobe_legal;
		acc_next.miss       = miss;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			acc <= '0;
		end else begin
			acc <= acc_next;
		end
	end

endmodule

// File: source/scratchpad.sv
`timescale 1ns/1ps

module scratchpad #(
	parameter int MEM_WORDS = 64
) (
	input  logic              clk,
	input  logic              arst_n,
	input  perf_pkg::access_t acc,
	output logic [31:0]       read_data,
	output logic              read_response,
	output logic              write_response
);

	import perf_pkg::*;

	localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

	logic [31:0]      mem [MEM_WORDS];
	logic [IDX_W-1:0] widx;
	logic [31:0]      hold_q;
	logic             is_read;
	logic             do_write;
	data_word_u       cur;
	data_word_u       merged;

	assign widx = IDX_W'(acc.word_index % 30'(MEM_WORDS));

	assign is_read  = (acc.kind == ACC_IREAD) || (acc.kind == ACC_DREAD);
	assign do_write = (acc.kind == ACC_DWRITE) && acc.strobe_ok;

	// the byte view lets each strobe bit pick its own lane
	always_comb begin
		cur.word = mem[widx];
		merged   = cur;
		for (int b = 0; b < 4; b++) begin
			if (acc.strobe[b]) begin
				merged.bytes[b] = acc.data.bytes[b];
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < MEM_WORDS; i++) begin
				mem[i] <= '0;
			end
		end else if (do_write) begin
			mem[widx] <= merged.word;
		end
	end

	always_ff @(posedge clk) begin
		if (is_read) begin
			hold_q <= cur.word;
		end
	end

	assign read_response  = is_read;
	assign write_response = (acc.kind == ACC_DWRITE);
	// keep showing the last read word between reads
	assign read_data      = is_read ? cur.word : hold_q;

endmodule

// File: source/event_counters.sv
`timescale 1ns/1ps

module event_counters #(
	parameter int COUNT_WIDTH = 16
) (
	input  logic                                            clk,
	input  logic                                            arst_n,
	input  perf_pkg::access_t                               acc,
	input  logic                                            report_start,
	input  logic                                            report_busy,
	output logic [perf_pkg::NUM_COUNTERS*COUNT_WIDTH-1:0]   snapshot,
	output logic                                            snap_load
);

	import perf_pkg::*;

	logic [COUNT_WIDTH-1:0]  count_q [NUM_COUNTERS];
	logic [NUM_COUNTERS-1:0] hit;
	logic                    take_snap;

	// a miss flag only counts alongside an access of its own class
	always_comb begin
		hit                  = '0;
		hit[CNT_IREADS]      = (acc.kind == ACC_IREAD);
		hit[CNT_DREADS]      = (acc.kind == ACC_DREAD);
		hit[CNT_DWRITES]     = (acc.kind == ACC_DWRITE);
		hit[CNT_BAD_STROBES] = (acc.kind == ACC_DWRITE) && !acc.strobe_ok;
		hit[CNT_L1I_MISSES]  = (acc.kind == ACC_IREAD) && acc.miss.l1i_miss;
		hit[CNT_L1D_MISSES]  = ((acc.kind == ACC_DREAD) || (acc.kind == ACC_DWRITE))
			&& acc.miss.l1d_miss;
		hit[CNT_L2_MISSES]   = (acc.kind != ACC_NONE) && acc.miss.l2_miss;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < NUM_COUNTERS; i++) begin
				count_q[i] <= '0;
			end
		end else begin
			for (int i = 0; i < NUM_COUNTERS; i++) begin
				if (hit[i] && (count_q[i] != {COUNT_WIDTH{1'b1}})) begin
					count_q[i] <= count_q[i] + COUNT_WIDTH'(1);
				end
			end
		end
	end

	assign take_snap = report_start && !report_busy;

	always_ff @(posedge clk) begin
		if (take_snap) begin
			for (int i = 0; i < NUM_COUNTERS; i++) begin
				snapshot[i*COUNT_WIDTH +: COUNT_WIDTH] <= count_q[i];
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			snap_load <= 1'b0;
		end else begin
			snap_load <= take_snap;
		end
	end

endmodule

// File: source/report_serializer.sv
`timescale 1ns/1ps

module report_serializer #(
	parameter int COUNT_WIDTH = 16
) (
	input  logic                                          clk,
	input  logic                                          arst_n,
	input  logic [perf_pkg::NUM_COUNTERS*COUNT_WIDTH-1:0] snapshot,
	input  logic                                          snap_load,
	input  logic                                          tx_busy,
	output logic [7:0]                                    tx_byte,
	output logic                                          tx_start,
	output logic                                          report_busy
);

	import perf_pkg::*;

	localparam int BYTES_PER = (COUNT_WIDTH + 7) / 8;
	localparam int NUM_BYTES = 1 + NUM_COUNTERS * BYTES_PER;
	localparam int IDX_W     = $clog2(NUM_BYTES);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_SEND,
		ST_WAIT
	} state_t;

	state_t             state_q;
	logic [IDX_W-1:0]   idx_q;
	logic [NUM_BYTES*8-1:0] frame;

	// sync byte first, then every counter padded to whole bytes, low byte first
	always_comb begin
		frame[7:0] = REPORT_SYNC;
		for (int c = 0; c < NUM_COUNTERS; c++) begin
			frame[8 + c*BYTES_PER*8 +: BYTES_PER*8] =
				(BYTES_PER*8)'(snapshot[c*COUNT_WIDTH +: COUNT_WIDTH]);
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state_q <= ST_IDLE;
			idx_q   <= '0;
		end else begin
			case (state_q)
				ST_IDLE: begin
					if (snap_load) begin
						idx_q   <= '0;
						state_q <= ST_SEND;
					end
				end
				ST_SEND: begin
					if (!tx_busy) begin
						state_q <= ST_WAIT;
					end
				end
				ST_WAIT: begin
					// tx_busy is already high the cycle after tx_start
					if (!tx_busy) begin
						if (idx_q == IDX_W'(NUM_BYTES - 1)) begin
							state_q <= ST_IDLE;
						end else begin
							idx_q   <= idx_q + 1'b1;
							state_q <= ST_SEND;
						end
					end
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	assign tx_byte     = frame[idx_q*8 +: 8];
	assign tx_start    = (state_q == ST_SEND) && !tx_busy;
	// snap_load covers the first cycle so busy rises right after report_start
	assign report_busy = (state_q != ST_IDLE) || snap_load;

endmodule

// File: source/uart_tx.sv
`timescale 1ns/1ps

module uart_tx #(
	parameter int CLKS_PER_BIT = 4
) (
	input  logic       clk,
	input  logic       arst_n,
	input  logic [7:0] din,
	input  logic       tx_start,
	output logic       tx_busy,
	output logic       tx
);

	localparam int CW = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

	logic [CW-1:0] clk_cnt;
	logic [3:0]    bit_cnt;
	logic [9:0]    shift_q;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			tx_busy <= 1'b0;
			clk_cnt <= '0;
			bit_cnt <= '0;
			shift_q <= '1;
		end else if (!tx_busy) begin
			if (tx_start) begin
				// stop bit, data LSB first, start bit
				shift_q <= {1'b1, din, 1'b0};
				tx_busy <= 1'b1;
				clk_cnt <= '0;
				bit_cnt <= '0;
			end
		end else if (clk_cnt == CW'(CLKS_PER_BIT - 1)) begin
			clk_cnt <= '0;
			shift_q <= {1'b1, shift_q[9:1]};
			if (bit_cnt == 4'd9) begin
				tx_busy <= 1'b0;
			end else begin
				bit_cnt <= bit_cnt + 4'd1;
			end
		end else begin
			clk_cnt <= clk_cnt + 1'b1;
		end
	end

	// ones shift in behind the frame so the line idles high
	assign tx = shift_q[0];

endmodule

// File: source/perf_monitor_top.sv
`timescale 1ns/1ps

module perf_monitor_top #(
	parameter logic [31:0] END_INST     = 32'h11fd8,
	parameter int          MEM_WORDS    = 64,
	parameter int          COUNT_WIDTH  = 16,
	parameter int          CLKS_PER_BIT = 4
) (
	input  logic                  clk,
	input  logic                  arst_n,
	input  perf_pkg::core_req_t   req,
	input  perf_pkg::miss_flags_t miss,
	input  logic                  report_start,
	output logic [31:0]           read_data,
	output logic                  read_response,
	output logic                  write_response,
	output logic                  report_busy,
	output logic                  tx
);

	import perf_pkg::*;

	access_t                             acc;
	logic [NUM_COUNTERS*COUNT_WIDTH-1:0] snapshot;
	logic                                snap_load;
	logic [7:0]                          tx_byte;
	logic                                tx_start;
	logic                                tx_busy;

	access_decode #(
		.END_INST(END_INST)
	) u_decode (
		.clk    (clk),
		.arst_n (arst_n),
		.req    (req),
		.miss   (miss),
		.acc    (acc)
	);

	scratchpad #(
		.MEM_WORDS(MEM_WORDS)
	) u_scratchpad (
		.clk            (clk),
		.arst_n         (arst_n),
		.acc            (acc),
		.read_data      (read_data),
		.read_response  (read_response),
		.write_response (write_response)
	);

	event_counters #(
		.COUNT_WIDTH(COUNT_WIDTH)
	) u_counters (
		.clk          (clk),
		.arst_n       (arst_n),
		.acc          (acc),
		.report_start (report_start),
		.report_busy  (report_busy),
		.snapshot     (snapshot),
		.snap_load    (snap_load)
	);

	report_serializer #(
		.COUNT_WIDTH(COUNT_WIDTH)
	) u_serializer (
		.clk         (clk),
		.arst_n      (arst_n),
		.snapshot    (snapshot),
		.snap_load   (snap_load),
		.tx_busy     (tx_busy),
		.tx_byte     (tx_byte),
		.tx_start    (tx_start),
		.report_busy (report_busy)
	);

	uart_tx #(
		.CLKS_PER_BIT(CLKS_PER_BIT)
	) u_tx (
		.clk      (clk),
		.arst_n   (arst_n),
		.din      (tx_byte),
		.tx_start (tx_start),
		.tx_busy  (tx_busy),
		.tx       (tx)
	);

endmodule

// File: verification/perf_monitor_checker.sv
`timescale 1ns/1ps

module perf_monitor_checker (
	input logic                clk,
	input logic                arst_n,
	input perf_pkg::core_req_t req,
	input logic                read_response,
	input logic                write_response,
	input logic                report_busy,
	input logic                tx
);

	// every response answers the request of the previous cycle and nothing else
	a_read_follows: assert property (@(posedge clk) disable iff (!arst_n)
		req.read_request |=> read_response)
		else $error("read_response missing one cycle after a read request");

	a_read_caused: assert property (@(posedge clk) disable iff (!arst_n)
		read_response |-> $past(req.read_request))
		else $error("read_response without a read request one cycle earlier");

	a_write_follows: assert property (@(posedge clk) disable iff (!arst_n)
		req.write_request |=> write_response)
		else $error("write_response missing one cycle after a write request");

	a_write_caused: assert property (@(posedge clk) disable iff (!arst_n)
		write_response |-> $past(req.write_request))
		else $error("write_response without a write request one cycle earlier");

	a_one_response: assert property (@(posedge clk) disable iff (!arst_n)
		!(read_response && write_response))
		else $error("read_response and write_response high together");

	a_tx_idle: assert property (@(posedge clk) disable iff (!arst_n)
		!report_busy |-> tx)
		else $error("tx low while no report is being sent");

endmodule

bind perf_monitor_top perf_monitor_checker u_checker (
	.clk            (clk),
	.arst_n         (arst_n),
	.req            (req),
	.read_response  (read_response),
	.write_response (write_response),
	.report_busy    (report_busy),
	.tx             (tx)
);

// File: verification/perf_monitor_tb.sv
`timescale 1ns/1ps

module perf_monitor_tb;

	import perf_pkg::*;

	localparam logic [31:0] END_INST     = 32'h11fd8;
	localparam int          MEM_WORDS    = 64;
	localparam int          COUNT_WIDTH  = 16;
	localparam int          CLKS_PER_BIT = 4;
	localparam int          CLK_PERIOD   = 40;
	localparam int          RESET_CYCLES = 8;
	localparam int          BYTES_PER    = (COUNT_WIDTH + 7) / 8;
	localparam int          NUM_BYTES    = 1 + NUM_COUNTERS * BYTES_PER;

	typedef struct packed {
		logic [7:0]  op;
		logic [31:0] addr;
		data_word_u  data;
		logic [3:0]  strobe;
		miss_flags_t miss;
		logic [31:0] expected;
	} trace_line_t;

	logic        clk;
	logic        arst_n;
	core_req_t   req;
	miss_flags_t miss;
	logic        report_start;
	logic [31:0] read_data;
	logic        read_response;
	logic        write_response;
	logic        report_busy;
	logic        tx;

	trace_line_t            trace_q[$];
	logic [7:0]             frame_expected [NUM_BYTES];
	logic [7:0]             frame_seen [NUM_BYTES];
	data_word_u             mem_model [MEM_WORDS];
	data_word_u             last_read;
	logic                   read_seen;
	logic [COUNT_WIDTH-1:0] count_model [NUM_COUNTERS];
	logic [COUNT_WIDTH-1:0] snap_model [NUM_COUNTERS];
	logic                   report_taken;
	int                     checks;
	int                     mismatches;
	int                     other_errors;
	int                     cycle_limit;
	int                     cycles;

	perf_monitor_top #(
		.END_INST     (END_INST),
		.MEM_WORDS    (MEM_WORDS),
		.COUNT_WIDTH  (COUNT_WIDTH),
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) dut (
		.clk            (clk),
		.arst_n         (arst_n),
		.req            (req),
		.miss           (miss),
		.report_start   (report_start),
		.read_data      (read_data),
		.read_response  (read_response),
		.write_response (write_response),
		.report_busy    (report_busy),
		.tx             (tx)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			mismatches++;
			$display("mismatch at time %0t: %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic end_run();
		$display("checks: %0d, mismatches: %0d, other errors: %0d",
			checks, mismatches, other_errors);
		if (mismatches == 0 && other_errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	endtask

	function automatic logic strobe_is_legal(input logic [3:0] s);
		case (s)
			4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100, 4'b1111: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	task automatic load_trace();
		int          fd;
		int          n;
		string       op;
		string       rest;
		trace_line_t t;
		logic [31:0] f [7];
		fd = $fopen("verification/perf_trace.txt", "r");
		if (fd == 0) begin
			other_errors++;
			$display("cannot open verification/perf_trace.txt");
			return;
		end
		while ($fscanf(fd, "%s", op) == 1) begin
			if (op.getc(0) == "#") begin
				n = $fgets(rest, fd);
			end else if (op == "E") begin
				for (int i = 0; i < NUM_BYTES; i++) begin
					n = $fscanf(fd, "%h", f[0]);
					if (n != 1) begin
						other_errors++;
						$display("the report line of the trace ends before byte %0d", i);
					end
					frame_expected[i] = f[0][7:0];
				end
			end else begin
				n = $fscanf(fd, "%h %h %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
				if (n != 7) begin
					other_errors++;
					$display("a trace line starting with %s has %0d fields instead of 7", op, n);
				end
				t.op            = op.getc(0);
				t.addr          = f[0];
				t.data.word     = f[1];
				t.strobe        = f[2][3:0];
				t.miss.l1i_miss = f[3][0];
				t.miss.l1d_miss = f[4][0];
				t.miss.l2_miss  = f[5][0];
				t.expected      = f[6];
				trace_q.push_back(t);
			end
		end
		$fclose(fd);
	endtask

	task automatic drive_line(input trace_line_t t);
		core_req_t r;
		r.read_request  = (t.op == "R");
		r.write_request = (t.op == "W");
		r.rw_address    = t.addr;
		r.write_data    = t.data.word;
		r.write_strobe  = t.strobe;
		req          <= r;
		miss         <= t.miss;
		report_start <= (t.op == "P");
	endtask

	task automatic bump(input counter_id_t id, input logic hit);
		if (hit && count_model[int'(id)] != {COUNT_WIDTH{1'b1}}) begin
			count_model[int'(id)]++;
		end
	endtask

	// responses belong to the line driven one cycle earlier
	task automatic score_line(input trace_line_t t);
		logic       is_read;
		logic       is_write;
		logic       is_inst;
		data_word_u word;
		int         idx;
		is_read  = (t.op == "R");
		is_write = (t.op == "W");
		is_inst  = is_read && (t.addr <= END_INST);
		idx      = t.addr[31:2] % MEM_WORDS;
		check_value("read_response", read_response, is_read);
		check_value("write_response", write_response, is_write);
		if (is_read) begin
			check_value("read_data", read_data, mem_model[idx].word);
			check_value("read_data (trace)", read_data, t.expected);
			last_read = mem_model[idx];
			read_seen = 1'b1;
		end else if (read_seen) begin
			// read_data keeps the word of the last read until the next one
			check_value("read_data (held)", read_data, last_read.word);
		end
		if (is_write && strobe_is_legal(t.strobe)) begin
			word = mem_model[idx];
			for (int b = 0; b < 4; b++) begin
				if (t.strobe[b]) begin
					word.bytes[b] = t.data.bytes[b];
				end
			end
			mem_model[idx] = word;
		end
		if (t.op == "P") begin
			check_value("report_busy", report_busy, 1'b1);
		end
		bump(CNT_IREADS, is_inst);
		bump(CNT_DREADS, is_read && !is_inst);
		bump(CNT_DWRITES, is_write);
		bump(CNT_BAD_STROBES, is_write && !strobe_is_legal(t.strobe));
		bump(CNT_L1I_MISSES, is_inst && t.miss.l1i_miss);
		bump(CNT_L1D_MISSES, ((is_read && !is_inst) || is_write) && t.miss.l1d_miss);
		bump(CNT_L2_MISSES, (is_read || is_write) && t.miss.l2_miss);
	endtask

	task automatic run_trace();
		trace_line_t prev;
		prev = '0;
		foreach (trace_q[i]) begin
			@(posedge clk);
			drive_line(trace_q[i]);
			// a report_start while a frame is going out is dropped
			if (trace_q[i].op == "P" && !report_taken) begin
				report_taken = 1'b1;
				snap_model   = count_model;
			end
			@(negedge clk);
			score_line(prev);
			prev = trace_q[i];
		end
		@(posedge clk);
		drive_line('0);
		@(negedge clk);
		score_line(prev);
	endtask

	// sample each bit in its middle, counting from the first low level seen
	task automatic receive_byte(input int index, output logic [7:0] value);
		value = '0;
		do begin
			@(negedge clk);
		end while (tx !== 1'b0);
		repeat (CLKS_PER_BIT / 2) @(negedge clk);
		if (tx !== 1'b0) begin
			other_errors++;
			$display("start bit of report byte %0d did not stay low", index);
		end
		for (int b = 0; b < 8; b++) begin
			repeat (CLKS_PER_BIT) @(negedge clk);
			value[b] = tx;
		end
		repeat (CLKS_PER_BIT) @(negedge clk);
		if (tx !== 1'b1) begin
			other_errors++;
			$display("stop bit of report byte %0d was low", index);
		end
	endtask

	task automatic collect_frame();
		for (int i = 0; i < NUM_BYTES; i++) begin
			receive_byte(i, frame_seen[i]);
		end
	endtask

	task automatic compare_frame();
		logic [7:0] model_byte;
		for (int i = 0; i < NUM_BYTES; i++) begin
			if (i == 0) begin
				model_byte = REPORT_SYNC;
			end else begin
				model_byte = 8'(snap_model[(i - 1) / BYTES_PER] >> (8 * ((i - 1) % BYTES_PER)));
			end
			check_value($sformatf("tx byte %0d", i), frame_seen[i], model_byte);
			check_value($sformatf("tx byte %0d (trace)", i), frame_seen[i], frame_expected[i]);
		end
	endtask

	task automatic watch_idle();
		for (int i = 0; i < NUM_BYTES * 10 * CLKS_PER_BIT / 2; i++) begin
			@(negedge clk);
			if (tx !== 1'b1 || report_busy !== 1'b0) begin
				other_errors++;
				$display("a second report frame started at time %0t", $time);
				break;
			end
		end
	endtask

	initial begin
		clk          = 1'b0;
		arst_n       = 1'b0;
		req          = '0;
		miss         = '0;
		report_start = 1'b0;
		report_taken = 1'b0;
		read_seen    = 1'b0;
		last_read    = '0;
		checks       = 0;
		mismatches   = 0;
		other_errors = 0;
		foreach (mem_model[i]) mem_model[i] = '0;
		foreach (count_model[i]) count_model[i] = '0;
		load_trace();
		if (trace_q.size() == 0) begin
			other_errors++;
			$display("the trace holds no request lines");
		end
		cycle_limit = trace_q.size() + NUM_BYTES * 10 * CLKS_PER_BIT * 2 + 100;
		repeat (RESET_CYCLES) @(posedge clk);
		arst_n <= 1'b1;
		@(negedge clk);
		check_value("read_response", read_response, 1'b0);
		check_value("write_response", write_response, 1'b0);
		check_value("report_busy", report_busy, 1'b0);
		check_value("tx", tx, 1'b1);
		fork
			run_trace();
			collect_frame();
		join
		compare_frame();
		while (report_busy) @(negedge clk);
		watch_idle();
		end_run();
	end

	initial begin
		cycles = 0;
		wait (cycle_limit > 0);
		while (cycles < cycle_limit) begin
			@(posedge clk);
			cycles++;
		end
		other_errors++;
		$display("timeout: the run did not finish within %0d cycles", cycle_limit);
		end_run();
	end

endmodule

// File: verification/perf_trace.txt
# op addr data strobe l1i l1d l2 expected, all hex; R read, W write, M idle, P report start
# the E line holds the report frame bytes in the order they leave the UART
M 00000000 00000000 0 0 0 0 00000000
R 00020000 00000000 0 0 0 0 00000000
R 00000010 00000000 0 1 0 1 00000000
W 00020000 11223344 f 0 1 0 00000000
R 00020000 00000000 0 0 0 0 11223344
W 00020000 000000aa 1 0 0 0 00000000
W 00020000 0000bb00 2 0 0 1 00000000
W 00020000 00cc0000 4 0 0 0 00000000
W 00020000 dd000000 8 0 1 0 00000000
R 00020000 00000000 0 0 1 1 ddccbbaa
W 00020004 55667788 f 0 0 0 00000000
W 00020004 0000eeff 3 1 0 0 00000000
W 00020004 99880000 c 0 0 0 00000000
R 00020004 00000000 0 0 0 0 9988eeff
W 00020004 12345678 5 0 1 1 00000000
W 00020004 12345678 0 0 0 0 00000000
R 00020004 00000000 0 0 0 0 9988eeff
W 00011fd8 cafef00d f 0 0 0 00000000
R 00011fd8 00000000 0 1 1 1 cafef00d
R 00011fdc 00000000 0 1 0 0 00000000
M 00000000 00000000 0 1 1 1 00000000
M 00000000 00000000 0 0 0 0 00000000
P 00000000 00000000 0 0 0 0 00000000
R 00020000 00000000 0 0 1 1 ddccbbaa
M 00000000 00000000 0 0 0 0 00000000
P 00000000 00000000 0 0 0 0 00000000
M 00000000 00000000 0 0 0 0 00000000
M 00000000 00000000 0 0 0 0 00000000
E a5 02 00 06 00 0b 00 02 00 02 00 04 00 05 00

// File: build.f
source/perf_pkg.sv
source/access_decode.sv
source/scratchpad.sv
source/event_counters.sv
source/report_serializer.sv
source/uart_tx.sv
source/perf_monitor_top.sv
verification/perf_monitor_checker.sv
verification/perf_monitor_tb.sv

// File: Bender.yml
package:
  name: perf_monitor

sources:
  - files:
      - source/perf_pkg.sv
      - source/access_decode.sv
      - source/scratchpad.sv
      - source/event_counters.sv
      - source/report_serializer.sv
      - source/uart_tx.sv
      - source/perf_monitor_top.sv
  - target: test
    files:
      - verification/perf_monitor_checker.sv
      - verification/perf_monitor_tb.sv
